//--- common/ice_settings.svh
`ifndef ICE_SETTINGS_SVH
`define ICE_SETTINGS_SVH

//////////////////////////////
// Memory sizes
//////////////////////////////

// Code store in bytes, power of two, at least 8 for the demo program
`define ICE_CODE_BYTES 16

`define ICE_XRAM_BYTES 16    // External data RAM in bytes, power of two

//////////////////////////////
// Bus
//////////////////////////////

`define ICE_ADDR_W 16        // Fetch and XRAM address width

`endif

//--- common/ice_bus_pkg.sv
`include "ice_settings.svh"

package ice_bus_pkg;

   typedef logic [7:0]             byte_t;
   typedef logic [`ICE_ADDR_W-1:0] addr_t;

   // Four code bytes, byte at fetch address in [7:0]
   typedef logic [31:0]            fetch_word_t;

   // Instruction fetch request
   typedef struct packed {
      addr_t   addr;
   } code_req_t;

   // External data request
   typedef struct packed {
      addr_t   addr;
      logic    we;       // 1 = write
      byte_t   wdata;    // Ignored on reads
   } xram_req_t;

endpackage

//--- common/ice_dbg_pkg.sv
package ice_dbg_pkg;

   // Host debug commands
   typedef enum logic [1:0] {
      DBG_CODE_WR = 2'd0,     // Direct byte store into code memory
      DBG_CODE_RD = 2'd1,     // Low byte of a fetch window
      DBG_XRAM_WR = 2'd2,
      DBG_XRAM_RD = 2'd3
   } dbg_cmd_e;

   // Code writes bypass the arbiter, every other command
   // competes with the CPU for its memory

endpackage

//--- logic/bus_arbiter.sv
`timescale 1ns/1ns

module bus_arbiter #(
   parameter type REQ_T = logic [15:0],
   parameter type RD_T  = logic [7:0]
) (
   input  logic   i_clk,
   input  logic   i_nrst,
   // Master 0
   input  logic   i_m0_stb,
   input  REQ_T   i_m0_req,
   output logic   o_m0_ack,
   output RD_T    o_m0_rdata,
   // Master 1
   input  logic   i_m1_stb,
   input  REQ_T   i_m1_req,
   output logic   o_m1_ack,
   output RD_T    o_m1_rdata,
   // Slave
   output logic   o_s_stb,
   output REQ_T   o_s_req,
   input  logic   i_s_ack,
   input  RD_T    i_s_rdata
);

   logic busy_q;     // An access is owned by grant_q
   logic grant_q;    // 0 = master 0, 1 = master 1
   logic last_q;     // Master served by the last finished access
   logic pick;

   //////////////////////////////
   // Grant selection
   //////////////////////////////

   // On a tie the master not served last goes first
   always_comb begin
      if (i_m0_stb && i_m1_stb) begin
         pick = ~last_q;
      end else begin
         pick = i_m1_stb;
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         busy_q  <= 1'b0;
         grant_q <= 1'b0;
         last_q  <= 1'b1;           // Master 0 wins the first tie
      end else begin
         if (!busy_q) begin
            if (i_m0_stb || i_m1_stb) begin
               busy_q  <= 1'b1;
               grant_q <= pick;
            end
         end else if (i_s_ack) begin
            busy_q <= 1'b0;         // Free again next cycle
            last_q <= grant_q;
         end
      end
   end

   //////////////////////////////
   // Forward and return paths
   //////////////////////////////

   // Owner keeps its strobe up until ack
   assign o_s_stb = busy_q && (grant_q ? i_m1_stb : i_m0_stb);
   assign o_s_req = grant_q ? i_m1_req : i_m0_req;

   assign o_m0_ack = i_s_ack && busy_q && !grant_q;
   assign o_m1_ack = i_s_ack && busy_q && grant_q;

   // Read data only reaches the owner, and only with its ack
   assign o_m0_rdata = o_m0_ack ? i_s_rdata : RD_T'('0);
   assign o_m1_rdata = o_m1_ack ? i_s_rdata : RD_T'('0);

endmodule

//--- code_mem/code_mem.sv
`timescale 1ns/1ns
`include "ice_settings.svh"

module code_mem (
   input  logic                      i_clk,
   input  logic                      i_nrst,
   // Fetch slave
   input  logic                      i_stb,
   input  ice_bus_pkg::code_req_t    i_req,
   output logic                      o_ack,
   output ice_bus_pkg::fetch_word_t  o_rdata,
   // Host write port
   input  logic                      i_wr,
   input  ice_bus_pkg::addr_t        i_wr_addr,
   input  ice_bus_pkg::byte_t        i_wr_data
);

   localparam int AW = $clog2(`ICE_CODE_BYTES);

   ice_bus_pkg::byte_t        mem [`ICE_CODE_BYTES];
   logic [AW-1:0]             base;
   ice_bus_pkg::fetch_word_t  window;
   logic                      start;

   // Reset image: inc A / mov DPTR,#0 / movx @DPTR,A / sjmp back
   function automatic ice_bus_pkg::byte_t demo_byte(input int idx);
      case (idx)
         0:       return 8'h04;   // inc A
         1:       return 8'h90;   // mov DPTR, #imm16
         4:       return 8'hF0;   // movx @DPTR, A
         5:       return 8'h80;   // sjmp
         6:       return 8'hF9;   // Offset -7, back to 0
         default: return 8'h00;
      endcase
   endfunction

   assign start = i_stb && !o_ack;    // One access per strobe
   assign base  = i_req.addr[AW-1:0];

   // Four bytes starting at base, wrapping at the top
   always_comb begin
      for (int k = 0; k < 4; k++) begin
         window[8*k +: 8] = mem[base + AW'(k)];
      end
   end

   //////////////////////////////
   // Storage and ack
   //////////////////////////////

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         for (int i = 0; i < `ICE_CODE_BYTES; i++) begin
            mem[i] <= demo_byte(i);
         end
         o_ack <= 1'b0;
      end else begin
         if (i_wr) begin
            mem[i_wr_addr[AW-1:0]] <= i_wr_data;
         end
         o_ack <= start;
      end
   end

   // Fetch word, valid with ack
   always_ff @(posedge i_clk) begin
      if (start) begin
         o_rdata <= window;
      end
   end

endmodule

//--- xram/xram.sv
`timescale 1ns/1ns
`include "ice_settings.svh"

module xram (
   input  logic                      i_clk,
   input  logic                      i_nrst,
   input  logic                      i_stb,
   input  ice_bus_pkg::xram_req_t    i_req,
   output logic                      o_ack,
   output ice_bus_pkg::byte_t        o_rdata,
   output logic [4:0]                o_led
);

   localparam int AW = $clog2(`ICE_XRAM_BYTES);

   ice_bus_pkg::byte_t  mem [`ICE_XRAM_BYTES];
   logic [AW-1:0]       addr;
   logic                start;

   assign addr  = i_req.addr[AW-1:0];   // Wraps at the top
   assign start = i_stb && !o_ack;

   //////////////////////////////
   // Access
   //////////////////////////////

   // Read data stays zero outside a read ack
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         for (int i = 0; i < `ICE_XRAM_BYTES; i++) begin
            mem[i] <= 8'h00;
         end
         o_ack   <= 1'b0;
         o_rdata <= 8'h00;
      end else begin
         if (start) begin
            if (i_req.we) begin
               mem[addr] <= i_req.wdata;
               o_rdata   <= 8'h00;
            end else begin
               o_rdata   <= mem[addr];
            end
            o_ack <= 1'b1;
         end else begin
            o_ack   <= 1'b0;
            o_rdata <= 8'h00;
         end
      end
   end

   // Board LEDs mirror byte 0
   assign o_led = mem[0][4:0];

endmodule

//--- logic/dbg_host_port.sv
`timescale 1ns/1ns

module dbg_host_port (
   input  logic                      i_clk,
   input  logic                      i_nrst,
   // Host side
   input  logic                      i_dbg_valid,
   input  ice_dbg_pkg::dbg_cmd_e     i_dbg_cmd,
   input  ice_bus_pkg::addr_t        i_dbg_addr,
   input  ice_bus_pkg::byte_t        i_dbg_wdata,
   output logic                      o_dbg_busy,
   output logic                      o_dbg_rvalid,
   output ice_bus_pkg::byte_t        o_dbg_rdata,
   // Code arbiter, master 1
   output logic                      o_code_stb,
   output ice_bus_pkg::code_req_t    o_code_req,
   input  logic                      i_code_ack,
   input  ice_bus_pkg::fetch_word_t  i_code_rdata,
   // Direct code write
   output logic                      o_code_wr,
   output ice_bus_pkg::addr_t        o_code_wr_addr,
   output ice_bus_pkg::byte_t        o_code_wr_data,
   // XRAM arbiter, master 1
   output logic                      o_xram_stb,
   output ice_bus_pkg::xram_req_t    o_xram_req,
   input  logic                      i_xram_ack,
   input  ice_bus_pkg::byte_t        i_xram_rdata
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_CODE_WR,
      S_CODE_RD,
      S_XRAM
   } state_e;

   state_e                 state;
   ice_dbg_pkg::dbg_cmd_e  cmd_q;
   ice_bus_pkg::addr_t     addr_q;
   ice_bus_pkg::byte_t     wdata_q;
   logic                   accept;
   logic                   xram_rd;

   assign accept  = i_dbg_valid && (state == S_IDLE);   // Dropped while busy
   assign xram_rd = (cmd_q == ice_dbg_pkg::DBG_XRAM_RD);

   // Command latch
   always_ff @(posedge i_clk) begin
      if (accept) begin
         cmd_q   <= i_dbg_cmd;
         addr_q  <= i_dbg_addr;
         wdata_q <= i_dbg_wdata;
      end
   end

   //////////////////////////////
   // Command FSM
   //////////////////////////////

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state        <= S_IDLE;
         o_dbg_rvalid <= 1'b0;
      end else begin
         o_dbg_rvalid <= 1'b0;
         case (state)
            S_IDLE: begin
               if (accept) begin
                  case (i_dbg_cmd)
                     ice_dbg_pkg::DBG_CODE_WR: state <= S_CODE_WR;
                     ice_dbg_pkg::DBG_CODE_RD: state <= S_CODE_RD;
                     default:                  state <= S_XRAM;
                  endcase
               end
            end
            S_CODE_WR: state <= S_IDLE;           // Byte lands on this edge
            S_CODE_RD: begin
               if (i_code_ack) begin
                  state        <= S_IDLE;
                  o_dbg_rvalid <= 1'b1;
               end
            end
            S_XRAM: begin
               if (i_xram_ack) begin
                  state        <= S_IDLE;
                  o_dbg_rvalid <= xram_rd;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // Returned byte, code reads keep the fetch address byte
   always_ff @(posedge i_clk) begin
      if (state == S_CODE_RD && i_code_ack) begin
         o_dbg_rdata <= i_code_rdata[7:0];
      end else if (state == S_XRAM && i_xram_ack && xram_rd) begin
         o_dbg_rdata <= i_xram_rdata;
      end
   end

   assign o_dbg_busy     = (state != S_IDLE);
   assign o_code_wr      = (state == S_CODE_WR);
   assign o_code_wr_addr = addr_q;
   assign o_code_wr_data = wdata_q;
   assign o_code_stb     = (state == S_CODE_RD);
   assign o_code_req     = ice_bus_pkg::code_req_t'{addr: addr_q};
   assign o_xram_stb     = (state == S_XRAM);
   assign o_xram_req     = ice_bus_pkg::xram_req_t'{addr: addr_q, we: !xram_rd, wdata: wdata_q};

endmodule

//--- logic/ice_top.sv
`timescale 1ns/1ns

module ice_top (
   input  logic                      i_clk,
   input  logic                      i_nrst,
   // CPU instruction fetch
   input  logic                      i_fetch_stb,
   input  ice_bus_pkg::addr_t        i_fetch_addr,
   output logic                      o_fetch_ack,
   output ice_bus_pkg::fetch_word_t  o_fetch_data,
   // CPU external data
   input  logic                      i_data_stb,
   input  logic                      i_data_we,
   input  ice_bus_pkg::addr_t        i_data_addr,
   input  ice_bus_pkg::byte_t        i_data_wdata,
   output logic                      o_data_ack,
   output ice_bus_pkg::byte_t        o_data_rdata,
   // Host debug
   input  logic                      i_dbg_valid,
   input  ice_dbg_pkg::dbg_cmd_e     i_dbg_cmd,
   input  ice_bus_pkg::addr_t        i_dbg_addr,
   input  ice_bus_pkg::byte_t        i_dbg_wdata,
   output logic                      o_dbg_busy,
   output logic                      o_dbg_rvalid,
   output ice_bus_pkg::byte_t        o_dbg_rdata,
   output logic [4:0]                o_led
);

   ice_bus_pkg::code_req_t    cpu_code_req;
   ice_bus_pkg::xram_req_t    cpu_xram_req;

   logic                      dbg_code_stb, dbg_code_ack, code_wr;
   ice_bus_pkg::code_req_t    dbg_code_req;
   ice_bus_pkg::fetch_word_t  dbg_code_rdata;
   ice_bus_pkg::addr_t        code_wr_addr;
   ice_bus_pkg::byte_t        code_wr_data;
   logic                      dbg_xram_stb, dbg_xram_ack;
   ice_bus_pkg::xram_req_t    dbg_xram_req;
   ice_bus_pkg::byte_t        dbg_xram_rdata;

   logic                      cm_stb, cm_ack, xr_stb, xr_ack;
   ice_bus_pkg::code_req_t    cm_req;
   ice_bus_pkg::fetch_word_t  cm_rdata;
   ice_bus_pkg::xram_req_t    xr_req;
   ice_bus_pkg::byte_t        xr_rdata;

   assign cpu_code_req = ice_bus_pkg::code_req_t'{addr: i_fetch_addr};
   assign cpu_xram_req = ice_bus_pkg::xram_req_t'{addr: i_data_addr, we: i_data_we,
                                                  wdata: i_data_wdata};

   //////////////////////////////
   // Code path, CPU is master 0
   //////////////////////////////

   bus_arbiter #(
      .REQ_T (ice_bus_pkg::code_req_t),
      .RD_T  (ice_bus_pkg::fetch_word_t)
   ) u_code_arb (
      .i_clk (i_clk), .i_nrst (i_nrst),
      .i_m0_stb (i_fetch_stb),  .i_m0_req (cpu_code_req),
      .o_m0_ack (o_fetch_ack),  .o_m0_rdata (o_fetch_data),
      .i_m1_stb (dbg_code_stb), .i_m1_req (dbg_code_req),
      .o_m1_ack (dbg_code_ack), .o_m1_rdata (dbg_code_rdata),
      .o_s_stb (cm_stb), .o_s_req (cm_req), .i_s_ack (cm_ack), .i_s_rdata (cm_rdata)
   );

   code_mem u_code_mem (
      .i_clk (i_clk), .i_nrst (i_nrst),
      .i_stb (cm_stb), .i_req (cm_req), .o_ack (cm_ack), .o_rdata (cm_rdata),
      .i_wr (code_wr), .i_wr_addr (code_wr_addr), .i_wr_data (code_wr_data)
   );

   //////////////////////////////
   // XRAM path
   //////////////////////////////

   bus_arbiter #(
      .REQ_T (ice_bus_pkg::xram_req_t),
      .RD_T  (ice_bus_pkg::byte_t)
   ) u_xram_arb (
      .i_clk (i_clk), .i_nrst (i_nrst),
      .i_m0_stb (i_data_stb),   .i_m0_req (cpu_xram_req),
      .o_m0_ack (o_data_ack),   .o_m0_rdata (o_data_rdata),
      .i_m1_stb (dbg_xram_stb), .i_m1_req (dbg_xram_req),
      .o_m1_ack (dbg_xram_ack), .o_m1_rdata (dbg_xram_rdata),
      .o_s_stb (xr_stb), .o_s_req (xr_req), .i_s_ack (xr_ack), .i_s_rdata (xr_rdata)
   );

   xram u_xram (
      .i_clk (i_clk), .i_nrst (i_nrst),
      .i_stb (xr_stb), .i_req (xr_req), .o_ack (xr_ack), .o_rdata (xr_rdata),
      .o_led (o_led)
   );

   dbg_host_port u_dbg (
      .i_clk (i_clk), .i_nrst (i_nrst),
      .i_dbg_valid (i_dbg_valid), .i_dbg_cmd (i_dbg_cmd),
      .i_dbg_addr (i_dbg_addr), .i_dbg_wdata (i_dbg_wdata),
      .o_dbg_busy (o_dbg_busy), .o_dbg_rvalid (o_dbg_rvalid), .o_dbg_rdata (o_dbg_rdata),
      .o_code_stb (dbg_code_stb), .o_code_req (dbg_code_req),
      .i_code_ack (dbg_code_ack), .i_code_rdata (dbg_code_rdata),
      .o_code_wr (code_wr), .o_code_wr_addr (code_wr_addr), .o_code_wr_data (code_wr_data),
      .o_xram_stb (dbg_xram_stb), .o_xram_req (dbg_xram_req),
      .i_xram_ack (dbg_xram_ack), .i_xram_rdata (dbg_xram_rdata)
   );

endmodule

//--- tb/tb_ice_top.sv
`timescale 1ns/1ns
`include "ice_settings.svh"

module tb_ice_top;

   localparam int CAW      = $clog2(`ICE_CODE_BYTES);
   localparam int XAW      = $clog2(`ICE_XRAM_BYTES);
   localparam int N_RAND   = 48;                     // Operations per random test
   localparam int N_OPS    = 6 * N_RAND + 8;
   localparam int WAIT_MAX = 100;                    // Cycles before an access counts as lost

   logic                      i_clk, i_nrst;
   logic                      i_fetch_stb, o_fetch_ack;
   ice_bus_pkg::addr_t        i_fetch_addr;
   ice_bus_pkg::fetch_word_t  o_fetch_data;
   logic                      i_data_stb, i_data_we, o_data_ack;
   ice_bus_pkg::addr_t        i_data_addr;
   ice_bus_pkg::byte_t        i_data_wdata, o_data_rdata;
   logic                      i_dbg_valid, o_dbg_busy, o_dbg_rvalid;
   ice_dbg_pkg::dbg_cmd_e     i_dbg_cmd;
   ice_bus_pkg::addr_t        i_dbg_addr;
   ice_bus_pkg::byte_t        i_dbg_wdata, o_dbg_rdata;
   logic [4:0]                o_led;

   int                  seed;
   int                  errors;
   int                  checks;
   ice_bus_pkg::byte_t  cmodel [`ICE_CODE_BYTES];   // Reference code store
   ice_bus_pkg::byte_t  xmodel [`ICE_XRAM_BYTES];   // Reference XRAM

   // Concurrent traffic drawn before the fork
   ice_bus_pkg::addr_t  cpu_a [N_RAND];
   ice_bus_pkg::addr_t  host_a [N_RAND];
   ice_bus_pkg::byte_t  cpu_d [N_RAND];
   ice_bus_pkg::byte_t  host_d [N_RAND];
   logic                cpu_w [N_RAND];
   logic                host_w [N_RAND];
   logic [1:0]          cpu_g [N_RAND];
   logic [1:0]          host_g [N_RAND];

   ice_top dut (.*);

   initial begin
      i_clk = 1'b0;
      forever #5 i_clk = ~i_clk;
   end

   initial begin
      repeat (N_OPS * 40 + 200) @(posedge i_clk);
      $display("Watchdog expired, the tests did not finish in time");
      $display("Checks: %0d, errors: %0d", checks, errors + 1);
      $display("Test failures found");
      $finish;
   end

   //////////////////////////////
   // Helpers
   //////////////////////////////

   function automatic logic [31:0] next_rand();
      next_rand = $random(seed);
   endfunction

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL @ %0t ns: %s got %h, expected %h", $time, what, got, exp);
      end
   endtask

   // Model bytes a to a+3 with wrap
   function automatic ice_bus_pkg::fetch_word_t model_window(input ice_bus_pkg::addr_t a);
      logic [CAW-1:0]            p;
      ice_bus_pkg::fetch_word_t  w;
      for (int k = 0; k < 4; k++) begin
         p = a[CAW-1:0] + CAW'(k);
         w[8*k +: 8] = cmodel[p];
      end
      return w;
   endfunction

   // CPU fetch entered on a falling edge and done in the cycle after ack
   task automatic fetch(input ice_bus_pkg::addr_t a, output ice_bus_pkg::fetch_word_t w,
                        output int cycles);
      i_fetch_stb  = 1'b1;
      i_fetch_addr = a;
      cycles       = 1;
      w            = '0;
      do begin
         @(negedge i_clk);
         cycles++;
      end while (!o_fetch_ack && cycles < WAIT_MAX);
      if (o_fetch_ack) begin
         w = o_fetch_data;
      end else begin
         errors++;
         $display("CPU fetch at %h never got an ack", a);
      end
      i_fetch_stb = 1'b0;
      @(negedge i_clk);
   endtask

   task automatic data_access(input logic we, input ice_bus_pkg::addr_t a,
                              input ice_bus_pkg::byte_t wd, output ice_bus_pkg::byte_t rd,
                              output int cycles);
      i_data_stb   = 1'b1;
      i_data_we    = we;
      i_data_addr  = a;
      i_data_wdata = wd;
      cycles       = 1;
      rd           = '0;
      do begin
         @(negedge i_clk);
         cycles++;
      end while (!o_data_ack && cycles < WAIT_MAX);
      if (o_data_ack) begin
         rd = o_data_rdata;
      end else begin
         errors++;
         $display("CPU data access at %h never got an ack", a);
      end
      i_data_stb = 1'b0;
      @(negedge i_clk);
   endtask

   // One host command that returns once busy has dropped
   task automatic host_cmd(input ice_dbg_pkg::dbg_cmd_e cmd, input ice_bus_pkg::addr_t a,
                           input ice_bus_pkg::byte_t wd, output ice_bus_pkg::byte_t rd);
      int   n;
      logic seen_rv;
      i_dbg_valid = 1'b1;
      i_dbg_cmd   = cmd;
      i_dbg_addr  = a;
      i_dbg_wdata = wd;
      @(negedge i_clk);
      i_dbg_valid = 1'b0;
      n           = 0;
      seen_rv     = 1'b0;
      rd          = '0;
      while (o_dbg_busy && n < WAIT_MAX) begin
         @(negedge i_clk);
         n++;
         if (o_dbg_rvalid) begin
            rd      = o_dbg_rdata;
            seen_rv = 1'b1;
         end
      end
      if (o_dbg_busy) begin
         errors++;
         $display("Host command %s at %h never finished", cmd.name(), a);
      end else if (!seen_rv && (cmd == ice_dbg_pkg::DBG_CODE_RD ||
                                cmd == ice_dbg_pkg::DBG_XRAM_RD)) begin
         errors++;
         $display("Host read %s at %h returned no data", cmd.name(), a);
      end
   endtask

   // Model follows each access in ack order
   task automatic cpu_data_op(input logic we, input ice_bus_pkg::addr_t a,
                              input ice_bus_pkg::byte_t wd);
      ice_bus_pkg::byte_t  rd;
      int                  c;
      data_access(we, a, wd, rd, c);
      if (we) begin
         xmodel[a[XAW-1:0]] = wd;
         if (a[XAW-1:0] == '0) check(32'(o_led), 32'(xmodel[0][4:0]), "LEDs after CPU write");
      end else begin
         check(32'(rd), 32'(xmodel[a[XAW-1:0]]), "CPU XRAM read");
      end
   endtask

   task automatic host_xram_op(input logic we, input ice_bus_pkg::addr_t a,
                               input ice_bus_pkg::byte_t wd);
      ice_bus_pkg::byte_t  rd;
      if (we) begin
         host_cmd(ice_dbg_pkg::DBG_XRAM_WR, a, wd, rd);
         xmodel[a[XAW-1:0]] = wd;
         if (a[XAW-1:0] == '0) check(32'(o_led), 32'(xmodel[0][4:0]), "LEDs after host write");
      end else begin
         host_cmd(ice_dbg_pkg::DBG_XRAM_RD, a, wd, rd);
         check(32'(rd), 32'(xmodel[a[XAW-1:0]]), "Host XRAM read");
      end
   endtask

   //////////////////////////////
   // Test sequence
   //////////////////////////////

   initial begin
      logic [31:0]               r;
      ice_bus_pkg::fetch_word_t  w;
      ice_bus_pkg::byte_t        rd;
      int                        c;

      seed         = 32'hbd72_2e83;
      errors       = 0;
      checks       = 0;
      i_nrst       = 1'b0;
      i_fetch_stb  = 1'b0;
      i_fetch_addr = '0;
      i_data_stb   = 1'b0;
      i_data_we    = 1'b0;
      i_data_addr  = '0;
      i_data_wdata = '0;
      i_dbg_valid  = 1'b0;
      i_dbg_cmd    = ice_dbg_pkg::DBG_CODE_RD;
      i_dbg_addr   = '0;
      i_dbg_wdata  = '0;
      for (int i = 0; i < `ICE_CODE_BYTES; i++) cmodel[i] = 8'h00;
      for (int i = 0; i < `ICE_XRAM_BYTES; i++) xmodel[i] = 8'h00;
      cmodel[0] = 8'h04;   // Demo program
      cmodel[1] = 8'h90;
      cmodel[4] = 8'hF0;
      cmodel[5] = 8'h80;
      cmodel[6] = 8'hF9;

      repeat (8) @(negedge i_clk);
      i_nrst = 1'b1;
      @(negedge i_clk);

      // Reset state
      check(32'(o_led), 32'h0, "LEDs after reset");
      fetch(16'h0000, w, c);
      check(w, 32'h0000_9004, "Fetch at 0");
      check(32'(c), 32'd3, "Fetch latency");
      fetch(16'h0004, w, c);
      check(w, 32'h00F9_80F0, "Fetch at 4");   // F0 80 F9 00, low byte first

      // Uncontested XRAM latency
      data_access(1'b1, 16'h0003, 8'h5A, rd, c);
      xmodel[3] = 8'h5A;
      check(32'(c), 32'd3, "CPU write latency");
      data_access(1'b0, 16'h0003, 8'h00, rd, c);
      check(32'(c), 32'd3, "CPU read latency");
      check(32'(rd), 32'h5A, "CPU read after write");

      // Random CPU data traffic led by a write that wraps onto byte 0
      r = next_rand();
      cpu_data_op(1'b1, 16'(`ICE_XRAM_BYTES), r[7:0]);
      for (int i = 0; i < N_RAND; i++) begin
         r = next_rand();
         cpu_data_op(r[16], r[15:0], r[31:24]);
      end

      // Host code loads against CPU fetches
      for (int i = 0; i < N_RAND; i++) begin
         r = next_rand();
         host_cmd(ice_dbg_pkg::DBG_CODE_WR, r[15:0], r[23:16], rd);
         cmodel[r[CAW-1:0]] = r[23:16];
         r = next_rand();
         fetch(r[15:0], w, c);
         check(w, model_window(r[15:0]), "Fetch window");
         host_cmd(ice_dbg_pkg::DBG_CODE_RD, r[31:16], 8'h00, rd);
         check(32'(rd), 32'(cmodel[r[16+CAW-1:16]]), "Host code read");
      end

      // CPU and host share the XRAM
      for (int i = 0; i < N_RAND; i++) begin
         r         = next_rand();
         cpu_a[i]  = r[15:0];
         cpu_w[i]  = r[16];
         cpu_g[i]  = r[18:17];
         cpu_d[i]  = r[31:24];
         r         = next_rand();
         host_a[i] = r[15:0];
         host_w[i] = r[16];
         host_g[i] = r[18:17];
         host_d[i] = r[31:24];
      end
      fork
         begin
            for (int i = 0; i < N_RAND; i++) begin
               repeat (cpu_g[i]) @(negedge i_clk);
               cpu_data_op(cpu_w[i], cpu_a[i], cpu_d[i]);
            end
         end
         begin
            for (int i = 0; i < N_RAND; i++) begin
               repeat (host_g[i]) @(negedge i_clk);
               host_xram_op(host_w[i], host_a[i], host_d[i]);
            end
         end
      join

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

//--- vlog.f
+incdir+common
common/ice_bus_pkg.sv
common/ice_dbg_pkg.sv
logic/bus_arbiter.sv
code_mem/code_mem.sv
xram/xram.sv
logic/dbg_host_port.sv
logic/ice_top.sv
tb/tb_ice_top.sv

//--- run_sim.sh
#!/bin/sh
# Builds tb_ice_top with Verilator, runs it and searches the log for the pass line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f vlog.f --top-module tb_ice_top -o sim_tb \
   && ./obj_dir/sim_tb > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "^All tests passed!$" sim.log \
   && { echo "Simulation PASSED"; exit 0; } \
   || { echo "Simulation FAILED"; exit 1; }
